/* Bender.yml */
package:
  name: fog_loop

sources:
  - include_dirs:
      - logic
    files:
      - logic/fog_pkg.sv
      - logic/fog_cfg_if.sv
      - logic/fog_apb_regs.sv
      - logic/fog_demod.sv
      - logic/fog_err_fifo.sv
      - logic/fog_feedback.sv
      - logic/fog_loop_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/fog_loop_properties.sv
      - bench/fog_loop_tb.sv

/* bench/fog_loop_properties.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_loop_properties (
	input logic       i_clk,
	input logic       i_arst_n,
	input logic       i_psel,
	input logic       i_penable,
	input logic       i_pready,
	input logic       i_pslverr,
	input logic       i_sync,
	input logic [2:0] i_fifo_level  // Internal FIFO fill
);

	int assert_fails = 0;  // Failed assertion count

	// No wait states, ever
	a_pready_high: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_pready)
		else begin
			assert_fails++;
			$error("PREADY went low");
		end

	// Sync marks a single cycle
	a_sync_width: assert property (@(posedge i_clk) disable iff (!i_arst_n) i_sync |=> !i_sync)
		else begin
			assert_fails++;
			$error("Sync pulse longer than one cycle");
		end

	a_fifo_bound: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_fifo_level <= `FOG_FIFO_DEPTH)
		else begin
			assert_fails++;
			$error("FIFO level above depth");
		end

	// Slave error only while the access phase is on the bus
	a_slverr_phase: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_pslverr |-> (i_psel && i_penable))
		else begin
			assert_fails++;
			$error("PSLVERR outside access phase");
		end

endmodule

bind fog_loop_top fog_loop_properties u_props (
	.i_clk        (i_clk),
	.i_arst_n     (i_arst_n),
	.i_psel       (i_psel),
	.i_penable    (i_penable),
	.i_pready     (o_pready),
	.i_pslverr    (o_pslverr),
	.i_sync       (o_sync),
	.i_fifo_level (fifo_level)
);

/* bench/fog_loop_tb.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_loop_tb;
	import fog_pkg::*;

	// Budget: sync waits of the longest period plus bus accesses
	localparam int SYNC_WAITS  = 24;
	localparam int ACCESSES    = 80;
	localparam int TIMEOUT_CYC = SYNC_WAITS * 2 * `FOG_FREQ_RST + ACCESSES * 4 + 200;

	logic                   clk;
	logic                   arst_n;
	logic                   psel, penable, pwrite;
	logic [`FOG_ADDR_W-1:0] paddr;
	logic [`FOG_WORD_W-1:0] pwdata, prdata;
	logic                   pready, pslverr;
	sample_t                adc;
	dac_t                   dac;
	logic                   sync;

	logic [31:0] rng_state = 32'hc215;
	int          word_errs, dac_errs, flag_errs;
	int          cycles;
	int          ph;                    // Cycle index within period
	int          half_len = `FOG_FREQ_RST;
	sample_t     adc_a, adc_b;          // High and low half levels
	logic        last_slverr;
	err_t        loop_err;              // Constant error of the loop setup
	int          loop_gain;
	int          loop_pops;             // Closed loop integrations so far

	fog_loop_top DUT (
		.i_clk     (clk),
		.i_arst_n  (arst_n),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr),
		.i_adc     (adc),
		.o_dac     (dac),
		.o_sync    (sync)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ADC follows the modulation phase seen on sync
	always @(posedge clk) begin
		#10;
		if (sync)
			ph = 0;
		else
			ph = ph + 1;
		adc = (ph < half_len) ? adc_a : adc_b;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYC);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Error per period from the demod rule
	function automatic err_t expected_error(int len, int w, sample_t a, sample_t b, bit pol,
		err_t off);
		int n;
		n = len - w;  // Gated samples per half
		if (pol)
			return n * (int'(b) - int'(a)) - off;
		return n * (int'(a) - int'(b)) - off;
	endfunction

	task automatic check_word(input err_t got, input err_t exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
			word_errs++;
		end
	endtask

	task automatic check_dac(input dac_t got, input dac_t exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
			dac_errs++;
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
			flag_errs++;
		end
	endtask

	task automatic bus_idle();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_access(input logic wr, input logic [`FOG_ADDR_W-1:0] addr,
		input logic [`FOG_WORD_W-1:0] data, output logic [`FOG_WORD_W-1:0] rdata);
		@(posedge clk);
		#10;
		psel   = 1'b1;  // Setup phase
		pwrite = wr;
		paddr  = addr;
		pwdata = data;
		@(posedge clk);
		#10;
		penable = 1'b1;
		@(negedge clk);  // Mid access phase
		rdata       = prdata;
		last_slverr = pslverr;
		check_flag(pready, 1'b1, "PREADY in access phase");
		@(posedge clk);
		#10;
		bus_idle();
	endtask

	task automatic apb_write(input logic [`FOG_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [`FOG_ADDR_W-1:0] addr, output logic [31:0] data);
		apb_access(1'b0, addr, '0, data);
	endtask

	// Returns in the middle of the sync cycle
	task automatic wait_sync();
		do
			@(negedge clk);
		while (!sync);
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#10;
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#10;
		arst_n = 1'b1;
	endtask

	task automatic test_registers();
		logic [7:0]  addr [7];
		logic [31:0] wval [7];
		logic [31:0] rd;
		addr = '{`FOG_REG_CTRL, `FOG_REG_FREQ, `FOG_REG_AMP_H, `FOG_REG_AMP_L,
			`FOG_REG_WAIT, `FOG_REG_OFFSET, `FOG_REG_CONST};
		for (int i = 0; i < 7; i++) begin
			apb_read(addr[i], rd);
			check_word(rd, (i == 1) ? `FOG_FREQ_RST : 0, $sformatf("reset of 0x%02h", addr[i]));
		end
		apb_read(`FOG_REG_ERR, rd);
		check_word(rd, 0, "ERR after reset");
		apb_read(`FOG_REG_STEP, rd);
		check_word(rd, 0, "STEP after reset");
		apb_read(`FOG_REG_STATUS, rd);
		check_flag(rd[8], 1'b0, "overflow after reset");
		for (int i = 0; i < 7; i++) begin
			wval[i] = next_rand();
			if (i == 1)
				wval[i] = 8 + wval[i] % 8;  // Keep the period short
			apb_write(addr[i], wval[i]);
			check_flag(last_slverr, 1'b0, "PSLVERR on valid write");
		end
		half_len = wval[1];
		for (int i = 0; i < 7; i++) begin
			apb_read(addr[i], rd);
			check_word(rd, (i == 0) ? (wval[i] & 32'hff) : wval[i],
				$sformatf("readback of 0x%02h", addr[i]));
		end
		apb_write(8'h28, next_rand());  // Hole above STATUS
		check_flag(last_slverr, 1'b1, "PSLVERR on unmapped write");
		apb_read(8'h28, rd);
		check_flag(last_slverr, 1'b1, "PSLVERR on unmapped read");
		apb_write(`FOG_REG_ERR, next_rand());
		check_flag(last_slverr, 1'b1, "PSLVERR on ERR write");
		apb_write(`FOG_REG_STATUS, next_rand());
		check_flag(last_slverr, 1'b1, "PSLVERR on STATUS write");
		apb_read(`FOG_REG_CONST, rd);
		check_word(rd, wval[6], "CONST after rejected writes");
		apb_write(`FOG_REG_CTRL, 32'h0);
	endtask

	// Fixed loop setup, feedback off
	task automatic config_loop(input bit pol, output err_t e);
		logic [31:0] f, w;
		err_t        off;
		int          len;
		f     = 8 + next_rand() % 8;
		w     = next_rand() % 4;
		off   = next_rand() % 1024;
		adc_a = sample_t'(int'(next_rand() % 4000) - 2000);
		adc_b = sample_t'(int'(next_rand() % 4000) - 2000);
		len   = (f < `FOG_FREQ_MIN) ? `FOG_FREQ_MIN : f;
		apb_write(`FOG_REG_FREQ, f);
		apb_write(`FOG_REG_WAIT, w);
		apb_write(`FOG_REG_OFFSET, off);
		apb_write(`FOG_REG_CTRL, pol ? 32'h2 : 32'h0);
		half_len = len;
		e = expected_error(len, w, adc_a, adc_b, pol, off);
	endtask

	task automatic test_demod(input bit pol);
		err_t        e;
		logic [31:0] rd;
		config_loop(pol, e);
		wait_sync();  // First clean period starts
		wait_sync();
		apb_read(`FOG_REG_ERR, rd);
		check_word(rd, e, pol ? "ERR with polarity 1" : "ERR with polarity 0");
	endtask

	task automatic test_fb_off();
		logic [31:0] c, rd;
		c = next_rand();
		apb_write(`FOG_REG_CONST, c);
		apb_write(`FOG_REG_CTRL, 32'h0);
		wait_sync();
		apb_read(`FOG_REG_STEP, rd);
		check_word(rd, c, "STEP with feedback off");
	endtask

	task automatic test_fb_on(input int n);
		logic [31:0] rd;
		apb_write(`FOG_REG_CONST, 32'h0);
		config_loop(1'b0, loop_err);
		wait_sync();
		wait_sync();  // Step now zero
		apb_read(`FOG_REG_ERR, rd);
		check_word(rd, loop_err, "ERR before closing the loop");
		loop_gain = next_rand() % 4;
		apb_write(`FOG_REG_CTRL, 32'h1 | (32'(loop_gain) << 3));
		repeat (n) wait_sync();
		apb_read(`FOG_REG_STEP, rd);
		check_word(rd, n * (loop_err >>> loop_gain), "STEP after integrations");
		loop_pops = n;
	endtask

	task automatic test_backpressure();
		logic [31:0] rd, s0;
		err_t        inc;
		inc = loop_err >>> loop_gain;  // One integration
		wait_sync();
		apb_write(`FOG_REG_CTRL, 32'h5 | (32'(loop_gain) << 3));  // fb_on and hold
		apb_read(`FOG_REG_STEP, s0);
		loop_pops++;  // Popped before hold landed
		check_word(s0, loop_pops * inc, "STEP when hold is set");
		repeat (6) wait_sync();  // Two errors dropped
		apb_read(`FOG_REG_STATUS, rd);
		check_word(rd[2:0], 4, "FIFO level while held");
		check_flag(rd[8], 1'b1, "overflow while held");
		apb_read(`FOG_REG_STATUS, rd);
		check_word(rd[2:0], 4, "FIFO level on second read");
		check_flag(rd[8], 1'b0, "overflow after clearing read");
		wait_sync();
		apb_write(`FOG_REG_CTRL, 32'h1 | (32'(loop_gain) << 3));
		repeat (6) @(posedge clk);  // FIFO drains, next sync far off
		apb_read(`FOG_REG_STEP, rd);
		loop_pops += 4;
		check_word(rd, loop_pops * inc, "STEP after release");
	endtask

	task automatic test_dac();
		logic [31:0] amp_h, amp_l, c;
		err_t        ramp;
		apply_reset();
		half_len = `FOG_FREQ_RST;
		amp_h    = next_rand();
		amp_l    = next_rand();
		c        = next_rand();
		apb_write(`FOG_REG_AMP_H, amp_h);  // All done before the first sync
		apb_write(`FOG_REG_AMP_L, amp_l);
		apb_write(`FOG_REG_CONST, c);
		for (int n = 1; n <= 3; n++) begin
			wait_sync();
			ramp = n * c;  // One step per popped error
			repeat (half_len - 1) @(negedge clk);
			check_dac(dac, dac_t'(ramp[31:16] + amp_h[15:0]), "DAC in high half");
			repeat (half_len) @(negedge clk);
			check_dac(dac, dac_t'(ramp[31:16] + amp_l[15:0]), "DAC in low half");
		end
	endtask

	initial begin
		arst_n = 1'b0;
		paddr  = '0;
		pwdata = '0;
		adc    = '0;
		adc_a  = '0;
		adc_b  = '0;
		bus_idle();
		apply_reset();
		test_registers();
		test_demod(1'b0);
		test_demod(1'b1);
		test_fb_off();
		test_fb_on(3);
		test_backpressure();
		test_dac();
		$display("Errors: %0d word, %0d dac, %0d flag mismatches, %0d assertion failures",
			word_errs, dac_errs, flag_errs, DUT.u_props.assert_fails);
		if (word_errs + dac_errs + flag_errs + DUT.u_props.assert_fails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+logic
logic/fog_pkg.sv
logic/fog_cfg_if.sv
logic/fog_apb_regs.sv
logic/fog_demod.sv
logic/fog_err_fifo.sv
logic/fog_feedback.sv
logic/fog_loop_top.sv
bench/fog_loop_properties.sv
bench/fog_loop_tb.sv

/* logic/fog_apb_regs.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_apb_regs (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [`FOG_ADDR_W-1:0] i_paddr,
	input  logic [`FOG_WORD_W-1:0] i_pwdata,
	output logic [`FOG_WORD_W-1:0] o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr,
	fog_cfg_if.regs_mp             cfg,
	input  fog_pkg::err_t          i_err,         // Last demod error
	input  fog_pkg::err_t          i_step,        // Current feedback step
	input  logic [2:0]             i_fifo_level,
	input  logic                   i_overflow     // One-cycle drop pulse
);
	import fog_pkg::*;

	reg_word_u ctrl_q, freq_q, amp_h_q, amp_l_q, wait_q, offset_q, const_q;
	reg_word_u wr_word;   // PWDATA, two views
	reg_word_u ctrl_wr;   // Masked control write
	logic      access, wr_en, rd_en;
	logic      mapped, read_only;
	logic      ovf_q;     // Sticky overflow
	logic [`FOG_WORD_W-1:0] rdata, status;

	assign access  = i_psel & i_penable;  // Access phase only
	assign wr_word = i_pwdata;
	assign status  = {{(`FOG_WORD_W-9){1'b0}}, ovf_q, 5'b0, i_fifo_level};

	// Address decode and readback mux
	always_comb begin
		mapped    = 1'b1;
		read_only = 1'b0;
		case (i_paddr)
			`FOG_REG_CTRL:   rdata = ctrl_q;
			`FOG_REG_FREQ:   rdata = freq_q;
			`FOG_REG_AMP_H:  rdata = amp_h_q;
			`FOG_REG_AMP_L:  rdata = amp_l_q;
			`FOG_REG_WAIT:   rdata = wait_q;
			`FOG_REG_OFFSET: rdata = offset_q;
			`FOG_REG_CONST:  rdata = const_q;
			`FOG_REG_ERR: begin
				rdata     = i_err;
				read_only = 1'b1;
			end
			`FOG_REG_STEP: begin
				rdata     = i_step;
				read_only = 1'b1;
			end
			`FOG_REG_STATUS: begin
				rdata     = status;
				read_only = 1'b1;
			end
			default: begin
				rdata  = '0;
				mapped = 1'b0;  // Hole in the map
			end
		endcase
	end

	// Only the defined control fields are kept
	always_comb begin
		ctrl_wr                = '0;
		ctrl_wr.ctrl.fb_on     = wr_word.ctrl.fb_on;
		ctrl_wr.ctrl.polarity  = wr_word.ctrl.polarity;
		ctrl_wr.ctrl.hold      = wr_word.ctrl.hold;
		ctrl_wr.ctrl.gain_step = wr_word.ctrl.gain_step;
	end

	assign wr_en     = access & i_pwrite & mapped & ~read_only;
	assign rd_en     = access & ~i_pwrite;
	assign o_pslverr = access & (~mapped | (i_pwrite & read_only));
	assign o_pready  = 1'b1;                  // No wait states
	assign o_prdata  = rd_en ? rdata : '0;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ctrl_q         <= '0;
			freq_q.value   <= `FOG_FREQ_RST;
			amp_h_q        <= '0;
			amp_l_q        <= '0;
			wait_q         <= '0;
			offset_q       <= '0;
			const_q        <= '0;
		end else if (wr_en) begin
			case (i_paddr)
				`FOG_REG_CTRL:   ctrl_q         <= ctrl_wr;
				`FOG_REG_FREQ:   freq_q.value   <= wr_word.value;
				`FOG_REG_AMP_H:  amp_h_q.value  <= wr_word.value;
				`FOG_REG_AMP_L:  amp_l_q.value  <= wr_word.value;
				`FOG_REG_WAIT:   wait_q.value   <= wr_word.value;
				`FOG_REG_OFFSET: offset_q.value <= wr_word.value;
				`FOG_REG_CONST:  const_q.value  <= wr_word.value;
				default:         ;              // Read-only already rejected
			endcase
		end
	end

	// New drop wins over a clearing read
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			ovf_q <= 1'b0;
		else if (i_overflow)
			ovf_q <= 1'b1;
		else if (rd_en && i_paddr == `FOG_REG_STATUS)
			ovf_q <= 1'b0;
	end

	assign cfg.ctrl       = ctrl_q.ctrl;
	assign cfg.freq_cnt   = freq_q.value;
	assign cfg.amp_h      = amp_h_q.value;
	assign cfg.amp_l      = amp_l_q.value;
	assign cfg.wait_cnt   = wait_q.value;
	assign cfg.err_offset = offset_q.value;
	assign cfg.const_step = const_q.value;

endmodule

/* logic/fog_cfg_if.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

// Loop settings from the register bank
interface fog_cfg_if;
	import fog_pkg::*;

	ctrl_fields_t           ctrl;
	logic [`FOG_WORD_W-1:0] freq_cnt;    // Half-period length, unclamped
	err_t                   amp_h;       // Mod level, high half
	err_t                   amp_l;       // Mod level, low half
	logic [`FOG_WORD_W-1:0] wait_cnt;    // Settling samples per half
	err_t                   err_offset;
	err_t                   const_step;  // Open loop step

	// Register bank side
	modport regs_mp (output ctrl, freq_cnt, amp_h, amp_l, wait_cnt, err_offset, const_step);

	// Modulation and demodulation
	modport demod_mp (input freq_cnt, amp_h, amp_l, wait_cnt, err_offset, ctrl);

	// Step integrator
	modport fb_mp (input ctrl, const_step);

endinterface

/* logic/fog_demod.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_demod (
	input  logic             i_clk,
	input  logic             i_arst_n,
	fog_cfg_if.demod_mp      cfg,
	input  fog_pkg::sample_t i_adc,
	output logic             o_sync,       // First cycle of high half
	output logic             o_err_valid,  // One pulse per period
	output fog_pkg::err_t    o_err,        // Held for readback
	output fog_pkg::err_t    o_mod_level
);
	import fog_pkg::*;

	logic                   half_lo;  // High half first
	logic [`FOG_WORD_W-1:0] k_q;      // Cycle index within half
	logic [`FOG_WORD_W-1:0] len_q;    // Half length latched at k == 0
	logic [`FOG_WORD_W-1:0] len_cfg, len_now;
	logic                   last, gate;
	err_t                   adc_ext, add, sum_h, sum_l, sum_l_nxt, diff;

	// Clamp to the minimum half length
	assign len_cfg = (cfg.freq_cnt < `FOG_FREQ_MIN) ? `FOG_FREQ_MIN : cfg.freq_cnt;
	assign len_now = (k_q == '0) ? len_cfg : len_q;
	assign last    = (k_q == len_now - 1'b1);

	assign adc_ext   = i_adc;                        // Sign extend
	assign gate      = (k_q >= cfg.wait_cnt);        // Past settling
	assign add       = gate ? adc_ext : '0;
	assign sum_l_nxt = sum_l + add;                  // Includes final sample
	assign diff      = cfg.ctrl.polarity ? (sum_l_nxt - sum_h) : (sum_h - sum_l_nxt);

	assign o_mod_level = half_lo ? cfg.amp_l : cfg.amp_h;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			half_lo     <= 1'b0;
			k_q         <= '0;
			len_q       <= '0;
			sum_h       <= '0;
			sum_l       <= '0;
			o_sync      <= 1'b0;
			o_err_valid <= 1'b0;
			o_err       <= '0;
		end else begin
			o_sync      <= last & half_lo;  // Next cycle starts a period
			o_err_valid <= last & half_lo;
			if (k_q == '0)
				len_q <= len_cfg;
			if (last) begin
				k_q     <= '0;
				half_lo <= ~half_lo;
			end else begin
				k_q <= k_q + 1'b1;
			end
			if (!half_lo) begin
				sum_h <= sum_h + add;
			end else if (last) begin
				// End of period, emit and restart both sums
				o_err <= diff - cfg.err_offset;
				sum_h <= '0;
				sum_l <= '0;
			end else begin
				sum_l <= sum_l_nxt;
			end
		end
	end

endmodule

/* logic/fog_err_fifo.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_err_fifo (
	input  logic                               i_clk,
	input  logic                               i_arst_n,
	input  logic                               i_push,
	input  fog_pkg::err_t                      i_data,
	output logic                               o_valid,
	output fog_pkg::err_t                      o_data,
	input  logic                               i_ready,
	output logic [$clog2(`FOG_FIFO_DEPTH):0]   o_level,
	output logic                               o_overflow  // Dropped push
);
	import fog_pkg::*;

	localparam int PTR_W = $clog2(`FOG_FIFO_DEPTH);

	err_t             mem [`FOG_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;  // Wrap at depth
	logic             full, do_push, do_pop;

	assign full       = (o_level == `FOG_FIFO_DEPTH);
	assign do_push    = i_push & ~full;      // Producer never stalls
	assign do_pop     = o_valid & i_ready;
	assign o_overflow = i_push & full;
	assign o_valid    = (o_level != '0);
	assign o_data     = mem[rd_ptr];

	always_ff @(posedge i_clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			o_level <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			o_level <= o_level + do_push - do_pop;  // Both cancel
		end
	end

endmodule

/* logic/fog_feedback.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_feedback (
	input  logic          i_clk,
	input  logic          i_arst_n,
	fog_cfg_if.fb_mp      cfg,
	input  logic          i_valid,
	input  fog_pkg::err_t i_err,
	output logic          o_ready,
	input  fog_pkg::err_t i_mod_level,
	output fog_pkg::err_t o_step,
	output fog_pkg::dac_t o_dac
);
	import fog_pkg::*;

	err_t step_q;
	err_t ramp_q;  // Phase ramp, wraps
	err_t inc;
	logic pop;
	logic upd_q;   // Step changed last cycle

	assign o_ready = ~cfg.ctrl.hold;             // Back-pressure
	assign pop     = i_valid & o_ready;
	assign inc     = i_err >>> cfg.ctrl.gain_step;  // Arithmetic gain
	assign o_step  = step_q;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			step_q <= '0;
			ramp_q <= '0;
			upd_q  <= 1'b0;
			o_dac  <= '0;
		end else begin
			upd_q <= pop;
			if (pop)
				step_q <= cfg.ctrl.fb_on ? (step_q + inc) : cfg.const_step;
			if (upd_q)
				ramp_q <= ramp_q + step_q;  // New step lands here
			// Ramp top bits plus mod level, 16-bit wrap
			o_dac <= ramp_q[`FOG_WORD_W-1 -: `FOG_DAC_W] + i_mod_level[`FOG_DAC_W-1:0];
		end
	end

endmodule

/* logic/fog_loop_top.sv */
`timescale 1ns/1ns
`include "fog_macros.svh"

module fog_loop_top (
	input  logic                   i_clk,
	input  logic                   i_arst_n,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [`FOG_ADDR_W-1:0] i_paddr,
	input  logic [`FOG_WORD_W-1:0] i_pwdata,
	output logic [`FOG_WORD_W-1:0] o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr,
	input  fog_pkg::sample_t       i_adc,
	output fog_pkg::dac_t          o_dac,
	output logic                   o_sync
);
	import fog_pkg::*;

	err_t       err, fifo_data, mod_level, step;
	logic       err_valid, fifo_valid, fb_ready, overflow;
	logic [2:0] fifo_level;

	fog_cfg_if cfg_if ();  // Settings bundle

	fog_apb_regs u_regs (
		.i_clk        (i_clk),
		.i_arst_n     (i_arst_n),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.cfg          (cfg_if.regs_mp),
		.i_err        (err),
		.i_step       (step),
		.i_fifo_level (fifo_level),
		.i_overflow   (overflow)
	);

	// Producer
	fog_demod u_demod (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.cfg         (cfg_if.demod_mp),
		.i_adc       (i_adc),
		.o_sync      (o_sync),
		.o_err_valid (err_valid),
		.o_err       (err),
		.o_mod_level (mod_level)
	);

	fog_err_fifo u_fifo (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_push     (err_valid),
		.i_data     (err),
		.o_valid    (fifo_valid),
		.o_data     (fifo_data),
		.i_ready    (fb_ready),
		.o_level    (fifo_level),
		.o_overflow (overflow)
	);

	// Consumer
	fog_feedback u_fb (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.cfg         (cfg_if.fb_mp),
		.i_valid     (fifo_valid),
		.i_err       (fifo_data),
		.o_ready     (fb_ready),
		.i_mod_level (mod_level),
		.o_step      (step),
		.o_dac       (o_dac)
	);

endmodule

/* logic/fog_macros.svh */
`ifndef FOG_MACROS_SVH
`define FOG_MACROS_SVH

// Datapath widths
`define FOG_WORD_W      32  // Register and error word
`define FOG_ADC_W       14  // ADC sample
`define FOG_DAC_W       16  // DAC word
`define FOG_FIFO_DEPTH  4   // Error FIFO entries
`define FOG_ADDR_W      8   // APB byte address

// APB register byte offsets
`define FOG_REG_CTRL    8'h00
`define FOG_REG_FREQ    8'h04  // Half-period length in clocks
`define FOG_REG_AMP_H   8'h08
`define FOG_REG_AMP_L   8'h0C
`define FOG_REG_WAIT    8'h10  // Samples skipped at start of each half
`define FOG_REG_OFFSET  8'h14
`define FOG_REG_CONST   8'h18  // Step used while feedback is off
`define FOG_REG_ERR     8'h1C  // Read only
`define FOG_REG_STEP    8'h20  // Read only
`define FOG_REG_STATUS  8'h24  // Read only, read clears overflow

// Reset value and clamp for half-period length
`define FOG_FREQ_RST    16
`define FOG_FREQ_MIN    4

`endif

/* logic/fog_pkg.sv */
`include "fog_macros.svh"

package fog_pkg;

	// Control register layout, bit 0 at the bottom
	typedef struct packed {
		logic [`FOG_WORD_W-9:0] reserved;   // Always reads zero
		logic [4:0]             gain_step;  // Error shift 0..31
		logic                   hold;       // Stalls the feedback pop
		logic                   polarity;   // Swap high/low in demod
		logic                   fb_on;      // Closed loop enable
	} ctrl_fields_t;

	// Signed error and step word
	typedef logic signed [`FOG_WORD_W-1:0] err_t;

	// One register word, seen either as a number or as control fields
	typedef union packed {
		err_t         value;
		ctrl_fields_t ctrl;
	} reg_word_u;

	// Raw converter words
	typedef logic signed [`FOG_ADC_W-1:0] sample_t;
	typedef logic [`FOG_DAC_W-1:0]        dac_t;  // Offset binary

endpackage
